/* hdl/dram_arbiter.sv */
`timescale 1ns/100ps
`include "mgr_settings.svh"

module dram_arbiter (
  input  logic                        clk,
  input  logic                        rst_n,
  // Read controllers
  input  logic [`MGR_NUM_STREAMS-1:0] rd_req,
  input  mgr_pkg::dram_addr_t         rd_addr [`MGR_NUM_STREAMS],
  output logic [`MGR_NUM_STREAMS-1:0] rd_gnt,
  output logic [`MGR_NUM_STREAMS-1:0] rd_valid,
  output mgr_pkg::lane_word_t         rd_data [`MGR_NUM_STREAMS],
  // Main memory read port
  output logic                        mem_rd_en,
  output mgr_pkg::dram_addr_t         mem_rd_addr,
  input  mgr_pkg::lane_word_t         mem_rd_data  // One cycle after mem_rd_en
);

  import mgr_pkg::*;

  stream_id_t prio;       // Requester checked first
  stream_id_t win_id;
  stream_id_t ret_id;     // Owner of the word coming back
  logic       any_gnt;
  logic       ret_valid;

  // --------------------
  // Round-robin pick
  // --------------------
  always_comb
  begin : pick
    stream_id_t cand;
    rd_gnt  = '0;
    win_id  = prio;
    any_gnt = 1'b0;
    for (int k = 0; k < `MGR_NUM_STREAMS; k++)
    begin
      cand = stream_id_t'(prio + k);  // Walk from the priority holder
      if (!any_gnt && rd_req[cand])
      begin
        rd_gnt[cand] = 1'b1;
        win_id       = cand;
        any_gnt      = 1'b1;
      end
    end
  end

  assign mem_rd_en   = any_gnt;
  assign mem_rd_addr = rd_addr[win_id];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      prio      <= '0;
      ret_valid <= 1'b0;
      ret_id    <= '0;
    end
    else
    begin
      ret_valid <= any_gnt;
      if (any_gnt)
      begin
        prio   <= stream_id_t'(win_id + 1'b1);  // Winner goes last next time
        ret_id <= win_id;
      end
    end
  end

  // Data fans out to all with valid only to the owner
  always_comb
  begin
    for (int i = 0; i < `MGR_NUM_STREAMS; i++)
    begin
      rd_valid[i] = ret_valid && (ret_id == stream_id_t'(i));
      rd_data[i]  = mem_rd_data;
    end
  end

endmodule

/* hdl/main_memory.sv */
`timescale 1ns/100ps
`include "mgr_settings.svh"

module main_memory (
  input  logic                clk,
  // Preload port
  input  logic                mem_wr_en,
  input  mgr_pkg::dram_addr_t mem_wr_addr,
  input  mgr_pkg::lane_word_t mem_wr_data,
  // Registered read port
  input  logic                mem_rd_en,
  input  mgr_pkg::dram_addr_t mem_rd_addr,
  output mgr_pkg::lane_word_t mem_rd_data
);

  import mgr_pkg::*;

  lane_word_t mem [`MGR_DRAM_DEPTH];

  // --------------------
  // Write
  // --------------------
  always_ff @(posedge clk)
  begin
    if (mem_wr_en)
      mem[mem_wr_addr] <= mem_wr_data;
  end

  // --------------------
  // Read
  // --------------------
  // Holds last word when idle
  always_ff @(posedge clk)
  begin
    if (mem_rd_en)
      mem_rd_data <= mem[mem_rd_addr];  // Old data on same-address write
  end

endmodule

/* hdl/manager.sv */
`timescale 1ns/100ps
`include "mgr_settings.svh"

module manager (
  input  logic                        clk,
  input  logic                        rst_n,
  // Instruction preload
  input  logic                        wu_wr_en,
  input  mgr_pkg::wu_addr_t           wu_wr_addr,
  input  mgr_pkg::wu_inst_t           wu_wr_data,
  // Memory preload
  input  logic                        mem_wr_en,
  input  mgr_pkg::dram_addr_t         mem_wr_addr,
  input  mgr_pkg::lane_word_t         mem_wr_data,
  // Run control
  input  logic                        start,
  input  mgr_pkg::wu_addr_t           start_addr,
  output logic                        busy,
  output logic                        done,
  // One downstream lane per stream
  output logic [`MGR_NUM_STREAMS-1:0] lane_valid,
  input  logic [`MGR_NUM_STREAMS-1:0] lane_ready,
  output mgr_pkg::lane_word_t         lane_data [`MGR_NUM_STREAMS]
);

  import mgr_pkg::*;

  // --------------------
  // Wires
  // --------------------
  logic [`MGR_NUM_STREAMS-1:0] desc_valid;
  logic [`MGR_NUM_STREAMS-1:0] desc_ready;
  mr_desc_t                    desc;                      // Common to all streams
  logic [`MGR_NUM_STREAMS-1:0] rd_req;
  dram_addr_t                  rd_addr [`MGR_NUM_STREAMS];
  logic [`MGR_NUM_STREAMS-1:0] rd_gnt;
  logic [`MGR_NUM_STREAMS-1:0] rd_valid;
  lane_word_t                  rd_data [`MGR_NUM_STREAMS];
  logic                        mem_rd_en;
  dram_addr_t                  mem_rd_addr;
  lane_word_t                  mem_rd_data;

  // Work-unit fetch, decode, dispatch
  wu_sequencer wu_sequencer (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .wu_wr_en   ( wu_wr_en   ),
    .wu_wr_addr ( wu_wr_addr ),
    .wu_wr_data ( wu_wr_data ),
    .start      ( start      ),
    .start_addr ( start_addr ),
    .busy       ( busy       ),
    .done       ( done       ),
    .desc_valid ( desc_valid ),
    .desc_ready ( desc_ready ),
    .desc       ( desc       )
  );

  // One read controller per stream
  genvar gvi;
  generate
    for (gvi = 0; gvi < `MGR_NUM_STREAMS; gvi++)
    begin : mrc_cntl_strm_inst
      mrc_cntl mrc_cntl (
        .clk        ( clk              ),
        .rst_n      ( rst_n            ),
        .desc_valid ( desc_valid[gvi]  ),
        .desc_ready ( desc_ready[gvi]  ),
        .desc       ( desc             ),
        .rd_req     ( rd_req[gvi]      ),
        .rd_addr    ( rd_addr[gvi]     ),
        .rd_gnt     ( rd_gnt[gvi]      ),
        .rd_valid   ( rd_valid[gvi]    ),
        .rd_data    ( rd_data[gvi]     ),
        .lane_valid ( lane_valid[gvi]  ),
        .lane_ready ( lane_ready[gvi]  ),
        .lane_data  ( lane_data[gvi]   )
      );
    end
  endgenerate

  // Shared single memory read port
  dram_arbiter dram_arbiter (
    .clk         ( clk         ),
    .rst_n       ( rst_n       ),
    .rd_req      ( rd_req      ),
    .rd_addr     ( rd_addr     ),
    .rd_gnt      ( rd_gnt      ),
    .rd_valid    ( rd_valid    ),
    .rd_data     ( rd_data     ),
    .mem_rd_en   ( mem_rd_en   ),
    .mem_rd_addr ( mem_rd_addr ),
    .mem_rd_data ( mem_rd_data )
  );

  main_memory main_memory (
    .clk         ( clk         ),
    .mem_wr_en   ( mem_wr_en   ),
    .mem_wr_addr ( mem_wr_addr ),
    .mem_wr_data ( mem_wr_data ),
    .mem_rd_en   ( mem_rd_en   ),
    .mem_rd_addr ( mem_rd_addr ),
    .mem_rd_data ( mem_rd_data )
  );

endmodule

/* hdl/mgr_pkg.sv */
`include "mgr_settings.svh"

package mgr_pkg;

  // --------------------
  // Addresses and words
  // --------------------
  typedef logic [$clog2(`MGR_WU_DEPTH)-1:0]    wu_addr_t;    // Instruction store index
  typedef logic [$clog2(`MGR_DRAM_DEPTH)-1:0]  dram_addr_t;  // Main memory word index
  typedef logic [`MGR_LANE_WIDTH-1:0]          lane_word_t;
  typedef logic [$clog2(`MGR_NUM_STREAMS)-1:0] stream_id_t;  // Which read controller
  typedef logic [`MGR_COUNT_WIDTH-1:0]         wu_count_t;

  // Opcode encoding 3 decodes like a NOP
  typedef enum logic [1:0] {
    NOP = 2'd0,
    MR  = 2'd1,  // Memory read toward one stream
    END = 2'd2   // Stops the run
  } wu_op_e;

  // --------------------
  // Work-unit instruction
  // --------------------
  typedef struct packed {
    wu_op_e     op;
    stream_id_t stream;  // Target controller for MR only
    dram_addr_t base;
    wu_count_t  count;   // Zero is legal and reads nothing
  } wu_inst_t;

  // Read descriptor handed to a controller
  typedef struct packed {
    dram_addr_t base;
    wu_count_t  count;
  } mr_desc_t;

endpackage

/* hdl/mgr_settings.svh */
`ifndef MGR_SETTINGS_SVH
`define MGR_SETTINGS_SVH

// --------------------
// Instruction store
// --------------------
`define MGR_WU_DEPTH          32   // Work-unit slots

// --------------------
// Main memory
// --------------------
`define MGR_DRAM_DEPTH        256  // Words preloaded from outside

// --------------------
// Streams and lanes
// --------------------
`define MGR_NUM_STREAMS       2    // One read controller per stream
`define MGR_LANE_WIDTH        32
`define MGR_COUNT_WIDTH       6    // Descriptor word count

// Per-controller queues
`define MGR_DESC_FIFO_DEPTH   2    // Active descriptor plus one waiting
`define MGR_DATA_FIFO_DEPTH   4    // Also the read credit limit

`endif

/* hdl/mrc_cntl.sv */
`timescale 1ns/100ps
`include "mgr_settings.svh"

module mrc_cntl (
  input  logic                clk,
  input  logic                rst_n,
  // From sequencer
  input  logic                desc_valid,
  output logic                desc_ready,
  input  mgr_pkg::mr_desc_t   desc,
  // To arbiter
  output logic                rd_req,
  output mgr_pkg::dram_addr_t rd_addr,
  input  logic                rd_gnt,
  input  logic                rd_valid,   // Return pulse for this stream only
  input  mgr_pkg::lane_word_t rd_data,
  // Downstream lane
  output logic                lane_valid,
  input  logic                lane_ready,
  output mgr_pkg::lane_word_t lane_data
);

  import mgr_pkg::*;

  localparam int CREDIT_W = $clog2(`MGR_DATA_FIFO_DEPTH + 1);

  mr_desc_t            desc_head;     // Descriptor being walked
  logic                desc_push;
  logic                desc_pop;
  logic                desc_full;
  logic                desc_empty;
  logic                data_empty;
  wu_count_t           offset;        // Words issued from current head
  logic [CREDIT_W-1:0] outstanding;   // In flight plus queued words
  logic                credit_ok;
  logic                zero_count;
  logic                last_word;
  logic                issue;
  logic                drain;

  // --------------------
  // Descriptor queue
  // --------------------
  assign desc_ready = !desc_full;
  assign desc_push  = desc_valid && desc_ready;

  stream_fifo #(
    .payload_t ( mr_desc_t            ),
    .DEPTH     ( `MGR_DESC_FIFO_DEPTH )
  ) desc_fifo (
    .clk       ( clk        ),
    .rst_n     ( rst_n      ),
    .push      ( desc_push  ),
    .push_data ( desc       ),
    .full      ( desc_full  ),
    .pop       ( desc_pop   ),
    .pop_data  ( desc_head  ),
    .empty     ( desc_empty )
  );

  // --------------------
  // Address walk
  // --------------------
  assign zero_count = (desc_head.count == '0);                        // Dropped unread
  assign last_word  = (offset == wu_count_t'(desc_head.count - 1'b1));
  assign credit_ok  = (outstanding < CREDIT_W'(`MGR_DATA_FIFO_DEPTH));

  // Head drives the request directly so first req follows acceptance
  assign rd_req   = !desc_empty && !zero_count && credit_ok;
  assign rd_addr  = desc_head.base + dram_addr_t'(offset);  // Wraps at memory depth
  assign issue    = rd_req && rd_gnt;
  assign desc_pop = !desc_empty && (zero_count || (issue && last_word));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      offset <= '0;
    else if (desc_pop)
      offset <= '0;  // Next descriptor starts at its base
    else if (issue)
      offset <= offset + 1'b1;
  end

  // Credits return when the lane takes a word
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      outstanding <= '0;
    else if (issue && !drain)
      outstanding <= outstanding + 1'b1;
    else if (drain && !issue)
      outstanding <= outstanding - 1'b1;
  end

  // --------------------
  // Return data queue
  // --------------------
  assign lane_valid = !data_empty;
  assign drain      = lane_valid && lane_ready;

  stream_fifo #(
    .payload_t ( lane_word_t          ),
    .DEPTH     ( `MGR_DATA_FIFO_DEPTH )
  ) data_fifo (
    .clk       ( clk        ),
    .rst_n     ( rst_n      ),
    .push      ( rd_valid   ),  // Credits keep this from overflowing
    .push_data ( rd_data    ),
    .full      (            ),
    .pop       ( drain      ),
    .pop_data  ( lane_data  ),
    .empty     ( data_empty )
  );

endmodule

/* hdl/stream_fifo.sv */
`timescale 1ns/100ps

module stream_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push,
  input  payload_t push_data,
  output logic     full,
  input  logic     pop,
  output payload_t pop_data,
  output logic     empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];  // Payload storage
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;       // Occupancy
  logic             do_push;
  logic             do_pop;

  assign full     = (count == CNT_W'(DEPTH));
  assign empty    = (count == '0);
  assign do_push  = push && !full;   // Push into a full queue is dropped
  assign do_pop   = pop && !empty;
  assign pop_data = mem[rd_ptr];     // Head is visible without a pop

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

  // Pointers wrap at DEPTH even if not a power of two
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

endmodule

/* hdl/wu_sequencer.sv */
`timescale 1ns/100ps
`include "mgr_settings.svh"

module wu_sequencer (
  input  logic                        clk,
  input  logic                        rst_n,
  // Instruction preload while idle
  input  logic                        wu_wr_en,
  input  mgr_pkg::wu_addr_t           wu_wr_addr,
  input  mgr_pkg::wu_inst_t           wu_wr_data,
  // Run control
  input  logic                        start,       // Single-cycle pulse
  input  mgr_pkg::wu_addr_t           start_addr,
  output logic                        busy,
  output logic                        done,
  // Descriptor dispatch with one valid per stream
  output logic [`MGR_NUM_STREAMS-1:0] desc_valid,
  input  logic [`MGR_NUM_STREAMS-1:0] desc_ready,
  output mgr_pkg::mr_desc_t           desc         // Shared by all streams
);

  import mgr_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FETCH,     // Store read in flight
    ST_DECODE,
    ST_DISPATCH   // MR held until its controller takes it
  } seq_state_e;

  wu_inst_t   store [`MGR_WU_DEPTH];
  wu_inst_t   inst_q;  // Instruction being decoded or dispatched
  wu_addr_t   pc;
  seq_state_e state;

  // --------------------
  // Work-unit store
  // --------------------
  always_ff @(posedge clk)
  begin
    if (wu_wr_en)
      store[wu_wr_addr] <= wu_wr_data;
  end

  // One-cycle registered read
  always_ff @(posedge clk)
  begin
    if (state == ST_FETCH)
      inst_q <= store[pc];
  end

  // --------------------
  // Fetch / decode FSM
  // --------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= ST_IDLE;
      pc    <= '0;
      busy  <= 1'b0;
      done  <= 1'b0;
    end
    else
    begin
      done <= 1'b0;  // Pulse
      case (state)
        ST_IDLE:
        begin
          if (start)  // Only sampled here and so ignored while busy
          begin
            pc    <= start_addr;
            busy  <= 1'b1;
            state <= ST_FETCH;
          end
        end
        ST_FETCH:
          state <= ST_DECODE;
        ST_DECODE:
        begin
          case (inst_q.op)
            MR:
              state <= ST_DISPATCH;
            END:
            begin
              done  <= 1'b1;   // Same cycle busy drops
              busy  <= 1'b0;
              state <= ST_IDLE;
            end
            default:
            begin
              pc    <= pc + 1'b1;  // Skip NOP
              state <= ST_FETCH;
            end
          endcase
        end
        ST_DISPATCH:
        begin
          if (desc_ready[inst_q.stream])
          begin
            pc    <= pc + 1'b1;  // Wraps past the last slot
            state <= ST_FETCH;
          end
        end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // Valid only toward the addressed controller
  always_comb
  begin
    desc_valid = '0;
    if (state == ST_DISPATCH)
      desc_valid[inst_q.stream] = 1'b1;
  end

  assign desc.base  = inst_q.base;   // Stable for the whole dispatch
  assign desc.count = inst_q.count;

endmodule

/* run.sh */
#!/bin/sh
# Build and run the manager testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_manager -o sim_tb_manager

out=$(./obj_dir/sim_tb_manager) || true
echo "$out"

if echo "$out" | grep -q "ALL CHECKS PASSED"; then
  exit 0
else
  exit 1
fi

/* test/tb_manager.sv */
`timescale 1ns/100ps
`include "mgr_settings.svh"

module tb_manager;

  import mgr_pkg::*;

  localparam int TIMEOUT = 5000;  // Cycles allowed per wait

  logic                        clk = 1'b0;
  logic                        rst_n;
  logic                        wu_wr_en;
  wu_addr_t                    wu_wr_addr;
  wu_inst_t                    wu_wr_data;
  logic                        mem_wr_en;
  dram_addr_t                  mem_wr_addr;
  lane_word_t                  mem_wr_data;
  logic                        start;
  wu_addr_t                    start_addr;
  logic                        busy;
  logic                        done;
  logic [`MGR_NUM_STREAMS-1:0] lane_valid;
  logic [`MGR_NUM_STREAMS-1:0] lane_ready;
  lane_word_t                  lane_data [`MGR_NUM_STREAMS];

  // Reference model state
  lane_word_t mem_model [`MGR_DRAM_DEPTH];
  wu_inst_t   prog [`MGR_WU_DEPTH];
  lane_word_t exp_q0 [$];  // Stream 0 words still owed
  lane_word_t exp_q1 [$];
  integer     seed;
  int         ready_mode;  // 0 always ready, 1 half, 2 mostly stalled
  int         done_count;
  int         runs;

  always #4 clk = ~clk;

  manager DUT (
    .clk         ( clk         ),
    .rst_n       ( rst_n       ),
    .wu_wr_en    ( wu_wr_en    ),
    .wu_wr_addr  ( wu_wr_addr  ),
    .wu_wr_data  ( wu_wr_data  ),
    .mem_wr_en   ( mem_wr_en   ),
    .mem_wr_addr ( mem_wr_addr ),
    .mem_wr_data ( mem_wr_data ),
    .start       ( start       ),
    .start_addr  ( start_addr  ),
    .busy        ( busy        ),
    .done        ( done        ),
    .lane_valid  ( lane_valid  ),
    .lane_ready  ( lane_ready  ),
    .lane_data   ( lane_data   )
  );

  // --------------------
  // Checks
  // --------------------
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_lane_word(input stream_id_t s, input lane_word_t got,
                                 input lane_word_t exp);
    if (got !== exp)
      fail_run($sformatf("Mismatch lane_data[%0d]: got %h expected %h", s, got, exp));
  endtask

  // Pops the model queue of one stream on each lane transfer
  task automatic take_word(input stream_id_t s, input lane_word_t got);
    lane_word_t exp;
    if (s == 1'b0)
    begin
      if (exp_q0.size() == 0)
        fail_run("Lane 0 delivered a word that the program never asked for");
      exp = exp_q0.pop_front();
    end
    else
    begin
      if (exp_q1.size() == 0)
        fail_run("Lane 1 delivered a word that the program never asked for");
      exp = exp_q1.pop_front();
    end
    check_lane_word(s, got, exp);
  endtask

  // Transfers happen where valid and ready meet at the rising edge
  always @(posedge clk)
  begin
    if (rst_n)
    begin
      if (lane_valid[0] && lane_ready[0])
        take_word(1'b0, lane_data[0]);
      if (lane_valid[1] && lane_ready[1])
        take_word(1'b1, lane_data[1]);
      if (done)
        done_count++;
    end
  end

  // --------------------
  // Stimulus helpers
  // --------------------
  // One cycle with new lane_ready on the falling edge
  task automatic tick();
    logic [31:0] r;
    @(negedge clk);
    r = $random(seed);
    case (ready_mode)
      0:       lane_ready = '1;
      1:       lane_ready = r[1:0];
      default: lane_ready = r[1:0] & r[3:2];
    endcase
  endtask

  function automatic wu_inst_t make_inst(input wu_op_e op, input stream_id_t s,
                                         input dram_addr_t b, input wu_count_t c);
    wu_inst_t inst;
    inst.op     = op;
    inst.stream = s;
    inst.base   = b;
    inst.count  = c;
    return inst;
  endfunction

  task automatic write_inst(input wu_addr_t a, input wu_inst_t inst);
    prog[a]    = inst;  // Model copy
    wu_wr_en   = 1'b1;
    wu_wr_addr = a;
    wu_wr_data = inst;
    tick();
    wu_wr_en   = 1'b0;
  endtask

  task automatic fill_memory();
    lane_word_t d;
    for (int a = 0; a < `MGR_DRAM_DEPTH; a++)
    begin
      d            = $random(seed);
      mem_model[a] = d;
      mem_wr_en    = 1'b1;
      mem_wr_addr  = dram_addr_t'(a);
      mem_wr_data  = d;
      tick();
    end
    mem_wr_en = 1'b0;
  endtask

  // Walk the program copy up to its first END with wrapping addresses
  task automatic build_expected(input wu_addr_t addr);
    wu_addr_t   pc;
    int         steps;
    lane_word_t w;
    pc    = addr;
    steps = 0;
    while (prog[pc].op != END)
    begin
      if (prog[pc].op == MR)
      begin
        for (int i = 0; i < int'(prog[pc].count); i++)
        begin
          w = mem_model[dram_addr_t'(prog[pc].base + i)];
          if (prog[pc].stream == 1'b0)
            exp_q0.push_back(w);
          else
            exp_q1.push_back(w);
        end
      end
      pc = pc + 5'd1;
      steps++;
      if (steps > `MGR_WU_DEPTH)
        fail_run("Test program holds no END instruction");
    end
  endtask

  // Whole store rewritten with END a few slots after a random start
  task automatic random_program(output wu_addr_t addr);
    logic [31:0] r;
    int          len;
    for (int i = 0; i < `MGR_WU_DEPTH; i++)
    begin
      r = $random(seed);
      case (r[1:0])
        2'd0:    write_inst(wu_addr_t'(i), make_inst(NOP, r[2], r[15:8], r[21:16]));
        2'd3:    write_inst(wu_addr_t'(i), make_inst(MR, r[2], r[15:8], 6'd0));
        default: write_inst(wu_addr_t'(i), make_inst(MR, r[2], r[15:8], {2'b00, r[19:16]}));
      endcase
    end
    r    = $random(seed);
    addr = r[4:0];
    len  = 2 + int'(r[10:8]);
    write_inst(addr + wu_addr_t'(len), make_inst(END, 1'b0, 8'h00, 6'd0));
  endtask

  // --------------------
  // One run from start to drain
  // --------------------
  task automatic run_program(input wu_addr_t addr);
    int cycles;
    build_expected(addr);
    check_flag("busy", busy, 1'b0);
    start      = 1'b1;
    start_addr = addr;
    tick();
    start = 1'b0;
    check_flag("busy", busy, 1'b1);  // Rises the cycle after start
    // Second start while busy must be ignored
    start      = 1'b1;
    start_addr = addr + 5'd7;
    tick();
    start  = 1'b0;
    runs++;
    cycles = 0;
    while (!done)
    begin
      check_flag("busy", busy, 1'b1);
      tick();
      cycles++;
      if (cycles > TIMEOUT)
        fail_run("The done pulse never came after start");
    end
    check_flag("busy", busy, 1'b0);  // Falls with done
    tick();
    check_flag("done", done, 1'b0);
    cycles = 0;
    while (exp_q0.size() != 0 || exp_q1.size() != 0 || lane_valid != '0)
    begin
      tick();
      cycles++;
      if (cycles > TIMEOUT)
        fail_run("The lanes did not deliver all expected words after done");
    end
    for (int i = 0; i < 8; i++)
    begin
      tick();
      check_flag("lane_valid[0]", lane_valid[0], 1'b0);
      check_flag("lane_valid[1]", lane_valid[1], 1'b0);
      check_flag("done", done, 1'b0);
    end
    if (done_count != runs)
      fail_run($sformatf("done pulsed %0d times over %0d runs", done_count, runs));
  endtask

  initial
  begin
    wu_addr_t addr;
    seed        = 32'h902ea266;
    rst_n       = 1'b0;
    wu_wr_en    = 1'b0;
    wu_wr_addr  = '0;
    wu_wr_data  = '0;
    mem_wr_en   = 1'b0;
    mem_wr_addr = '0;
    mem_wr_data = '0;
    start       = 1'b0;
    start_addr  = '0;
    lane_ready  = '0;
    ready_mode  = 0;
    done_count  = 0;
    runs        = 0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    // Idle after reset
    for (int i = 0; i < 6; i++)
    begin
      tick();
      check_flag("busy", busy, 1'b0);
      check_flag("done", done, 1'b0);
      check_flag("lane_valid[0]", lane_valid[0], 1'b0);
      check_flag("lane_valid[1]", lane_valid[1], 1'b0);
    end
    fill_memory();

    // One MR on stream 0 while lane 1 stays silent
    write_inst(5'd0, make_inst(MR, 1'b0, dram_addr_t'($random(seed)), 6'd12));
    write_inst(5'd1, make_inst(END, 1'b0, 8'h00, 6'd0));
    run_program(5'd0);

    // Start past an END so fetch wraps from slot 31 to 0
    ready_mode = 1;
    write_inst(5'd28, make_inst(END, 1'b0, 8'h00, 6'd0));
    write_inst(5'd29, make_inst(MR, 1'b0, 8'hf8, 6'd12));  // Memory wrap too
    write_inst(5'd30, make_inst(NOP, 1'b1, 8'h10, 6'd9));
    write_inst(5'd31, make_inst(MR, 1'b1, 8'h28, 6'd5));
    write_inst(5'd0, make_inst(MR, 1'b0, 8'h03, 6'd0));
    write_inst(5'd1, make_inst(MR, 1'b1, 8'h64, 6'd7));
    write_inst(5'd2, make_inst(END, 1'b0, 8'h00, 6'd0));
    run_program(5'd29);

    // Random mixes under back-pressure
    for (int n = 0; n < 10; n++)
    begin
      ready_mode = (n % 3 == 2) ? 2 : 1;
      random_program(addr);
      run_program(addr);
    end

    tick();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+hdl
hdl/mgr_pkg.sv
hdl/stream_fifo.sv
hdl/wu_sequencer.sv
hdl/mrc_cntl.sv
hdl/dram_arbiter.sv
hdl/main_memory.sv
hdl/manager.sv
test/tb_manager.sv
